/* hdl/cache_macros.svh */
// Geometry and address split of the L1 data cache
// Include wherever a width or array size is needed
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

`define L1_ADDR_W      32
`define L1_LINE_BYTES  16
`define L1_LINE_W      (`L1_LINE_BYTES * 8)

`define L1_NUM_WAYS    4
`define L1_WAY_W       2
`define L1_NUM_SETS    16

// Address = tag | index | byte offset
`define L1_INDEX_W     4
`define L1_OFFSET_W    4
`define L1_WORD_SEL_W  2
`define L1_TAG_W       24

`endif

/* hdl/cache_pkg.sv */
// Shared types of the L1 cache: bus and coherence encodings, address view
// and the bundles passed between the cache blocks
`include "cache_macros.svh"

package cache_pkg;

    typedef enum logic [2:0] {
        IDLE = 3'd0,
        RD   = 3'd1,    // Read for a shared copy
        RDX  = 3'd2,    // Read for ownership
        UPGR = 3'd3     // S to M, no data
    } bus_cmd_e;

    typedef enum logic [1:0] {
        I = 2'b00,
        S = 2'b01,
        M = 2'b10
    } msi_e;

    typedef logic [`L1_LINE_W-1:0] line_t;

    typedef struct packed {
        logic [`L1_TAG_W-1:0]    tag;
        logic [`L1_INDEX_W-1:0]  index;
        logic [`L1_OFFSET_W-1:0] offset;
    } cache_addr_s;

    // Raw word on the bus, split fields for lookup
    typedef union packed {
        logic [`L1_ADDR_W-1:0] raw;
        cache_addr_s           f;
    } cache_addr_u;

    typedef struct packed {
        logic [`L1_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
        logic [3:0]            byte_en;
        logic                  rd;
        logic                  wr;
    } cpu_req_s;

    typedef struct packed {
        logic                  req;
        bus_cmd_e              cmd;
        logic [`L1_ADDR_W-1:0] addr;
    } bus_req_s;

    typedef struct packed {
        logic                  wr;
        logic [`L1_ADDR_W-1:0] addr;   // Line aligned
        line_t                 wdata;
    } l2_wb_s;

    typedef struct packed {
        logic                  valid;
        bus_cmd_e              cmd;
        logic [`L1_ADDR_W-1:0] addr;
    } snoop_req_s;

    typedef struct packed {
        logic  hit;
        line_t data;
    } snoop_rsp_s;

    typedef struct packed {
        logic                hit;
        logic [`L1_WAY_W-1:0] way;
        msi_e                state;
    } lookup_s;

    typedef struct packed {
        logic                   en;
        logic [`L1_WAY_W-1:0]   way;
        logic [`L1_INDEX_W-1:0] set;
        logic [`L1_TAG_W-1:0]   tag;
        line_t                  data;
        msi_e                   state;
    } line_wr_s;

    // State only; I also drops valid
    typedef struct packed {
        logic                   en;
        logic [`L1_WAY_W-1:0]   way;
        logic [`L1_INDEX_W-1:0] set;
        msi_e                   state;
    } state_wr_s;

endpackage

/* hdl/cache_ctrl.sv */
// Request FSM of the L1 cache: hit check, upgrade, fetch and victim writeback
// Drives the store's line writes and the LRU touches for every finished access
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_pkg::cpu_req_s     cpu_req,
    output logic [31:0]             cpu_rdata,
    output logic                    cpu_ready,
    output cache_pkg::bus_req_s     bus_out,
    input  logic                    bus_grant,
    input  logic                    bus_valid,
    input  cache_pkg::line_t        bus_data_in,
    output cache_pkg::l2_wb_s       l2_wb,
    input  logic                    l2_ready,
    output cache_pkg::cache_addr_u  lookup_addr,
    input  cache_pkg::lookup_s      lookup,
    input  cache_pkg::line_t        hit_line,
    input  logic [`L1_WAY_W-1:0]    victim_way,
    input  cache_pkg::msi_e         victim_state,
    input  logic [`L1_TAG_W-1:0]    victim_tag,
    input  cache_pkg::line_t        victim_line,
    output cache_pkg::line_wr_s     line_wr,
    output logic                    lru_touch,
    output logic [`L1_WAY_W-1:0]    lru_touch_way
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_CAPTURE, ST_CHECK, ST_UPGR, ST_FETCH_S, ST_FETCH_X, ST_WB, ST_RESPOND
    } ctrl_state_e;

    ctrl_state_e                state_q;
    ctrl_state_e                state_d;
    ctrl_state_e                fetch_st;
    cpu_req_s                   req_q;
    logic [`L1_WAY_W-1:0]       way_q;     // Install way, hit or victim
    line_t                      line_q;    // Hit line kept for the upgrade merge
    logic [`L1_WORD_SEL_W-1:0]  word_sel;
    bus_cmd_e                   bus_cmd;
    logic                       start;
    logic                       bus_done;
    logic                       wb_done;

    assign lookup_addr = req_q.addr;
    assign word_sel    = lookup_addr.f.offset[`L1_OFFSET_W-1 -: `L1_WORD_SEL_W];
    assign start       = (state_q == ST_IDLE) && (cpu_req.rd || cpu_req.wr);
    assign fetch_st    = req_q.wr ? ST_FETCH_X : ST_FETCH_S;
    assign bus_done    = bus_out.req && bus_grant && bus_valid;
    assign wb_done     = l2_wb.wr && l2_ready;

    // Write data of the held request over one word of a line
    function automatic line_t merge_bytes(input line_t base);
        line_t r;
        r = base;
        for (int b = 0; b < 4; b++) begin
            if (req_q.byte_en[b]) r[word_sel*32 + b*8 +: 8] = req_q.wdata[b*8 +: 8];
        end
        return r;
    endfunction

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (start) state_d = ST_CAPTURE;
            ST_CAPTURE: state_d = ST_CHECK;
            ST_CHECK: begin
                if (lookup.hit && (req_q.rd || lookup.state == M)) begin
                    state_d = ST_RESPOND;
                end else if (lookup.hit) begin
                    state_d = ST_UPGR;         // Write to S
                end else if (victim_state == M) begin
                    state_d = ST_WB;           // Dirty victim leaves first
                end else begin
                    state_d = fetch_st;
                end
            end
            ST_UPGR, ST_FETCH_S, ST_FETCH_X: if (bus_done) state_d = ST_RESPOND;
            ST_WB:      if (wb_done) state_d = fetch_st;
            ST_RESPOND: state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_comb begin
        case (state_q)
            ST_UPGR:    bus_cmd = UPGR;
            ST_FETCH_S: bus_cmd = RD;
            ST_FETCH_X: bus_cmd = RDX;
            default:    bus_cmd = IDLE;
        endcase
    end

    // Levels follow the state, so both hold through any stall
    assign bus_out = '{req: (state_q inside {ST_UPGR, ST_FETCH_S, ST_FETCH_X}),
                       cmd: bus_cmd,
                       addr: req_q.addr};
    assign l2_wb   = '{wr: (state_q == ST_WB),
                       addr: {victim_tag, lookup_addr.f.index, {`L1_OFFSET_W{1'b0}}},
                       wdata: victim_line};

    always_comb begin
        line_wr.en    = 1'b0;
        line_wr.way   = way_q;
        line_wr.set   = lookup_addr.f.index;
        line_wr.tag   = lookup_addr.f.tag;
        line_wr.data  = bus_data_in;
        line_wr.state = S;
        case (state_q)
            ST_CHECK: begin                    // Write hit in M, merged in place
                line_wr.en    = lookup.hit && req_q.wr && (lookup.state == M);
                line_wr.way   = lookup.way;
                line_wr.data  = merge_bytes(hit_line);
                line_wr.state = M;
            end
            ST_UPGR: begin
                line_wr.en    = bus_done;
                line_wr.data  = merge_bytes(line_q);
                line_wr.state = M;
            end
            ST_FETCH_S: line_wr.en = bus_done;
            ST_FETCH_X: begin
                line_wr.en    = bus_done;
                line_wr.data  = merge_bytes(bus_data_in);
                line_wr.state = M;
            end
            ST_WB: begin                       // Victim goes invalid once L2 has it
                line_wr.en    = wb_done;
                line_wr.tag   = victim_tag;
                line_wr.data  = victim_line;
                line_wr.state = I;
            end
            default: ;
        endcase
    end

    assign lru_touch     = ((state_q == ST_CHECK) && (state_d == ST_RESPOND)) || bus_done;
    assign lru_touch_way = (state_q == ST_CHECK) ? lookup.way : way_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            req_q     <= '0;
            way_q     <= '0;
            cpu_ready <= 1'b0;
        end else begin
            state_q   <= state_d;
            cpu_ready <= (state_q == ST_RESPOND);
            if (start) req_q <= cpu_req;
            if (state_q == ST_CHECK) way_q <= lookup.hit ? lookup.way : victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_CHECK) begin
            line_q    <= hit_line;
            cpu_rdata <= hit_line[word_sel*32 +: 32];
        end
        if ((state_q == ST_FETCH_S) && bus_done) cpu_rdata <= bus_data_in[word_sel*32 +: 32];
    end

    a_bus_l2_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_out.req && l2_wb.wr));
    a_bus_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        bus_out.req |-> (bus_out.cmd != IDLE));
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ready |=> !cpu_ready);

endmodule

/* hdl/cache_store.sv */
// Valid, MSI state, tag and data arrays of the 4-way cache
// CPU and snoop ports look up in parallel; writes land at the next edge
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_store (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_pkg::cache_addr_u  cpu_addr,
    output cache_pkg::lookup_s      cpu_lookup,
    output cache_pkg::line_t        cpu_line,
    input  logic [`L1_WAY_W-1:0]    victim_way,
    output cache_pkg::msi_e         victim_state,
    output logic [`L1_TAG_W-1:0]    victim_tag,
    output cache_pkg::line_t        victim_line,
    input  cache_pkg::cache_addr_u  snoop_addr,
    output cache_pkg::lookup_s      snoop_lookup,
    output cache_pkg::line_t        snoop_line,
    input  cache_pkg::line_wr_s     line_wr,
    input  cache_pkg::state_wr_s    state_wr
);
    import cache_pkg::*;

    logic                    valid_q [`L1_NUM_WAYS][`L1_NUM_SETS];
    msi_e                    state_q [`L1_NUM_WAYS][`L1_NUM_SETS];
    logic [`L1_TAG_W-1:0]    tag_q   [`L1_NUM_WAYS][`L1_NUM_SETS];
    line_t                   data_q  [`L1_NUM_WAYS][`L1_NUM_SETS];
    logic [`L1_NUM_WAYS-1:0] cpu_match;
    logic [`L1_NUM_WAYS-1:0] snoop_match;

    function automatic logic [`L1_NUM_WAYS-1:0] match_ways(input cache_addr_u a);
        logic [`L1_NUM_WAYS-1:0] m;
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            m[w] = valid_q[w][a.f.index] && (tag_q[w][a.f.index] == a.f.tag);
        end
        return m;
    endfunction

    function automatic lookup_s encode(input logic [`L1_NUM_WAYS-1:0] m, input cache_addr_u a);
        lookup_s r;
        r = '{hit: 1'b0, way: '0, state: I};
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            if (m[w]) begin
                r.hit   = 1'b1;
                r.way   = w[`L1_WAY_W-1:0];
                r.state = state_q[w][a.f.index];
            end
        end
        return r;
    endfunction

    always_comb begin
        cpu_match    = match_ways(cpu_addr);
        snoop_match  = match_ways(snoop_addr);
        cpu_lookup   = encode(cpu_match, cpu_addr);
        snoop_lookup = encode(snoop_match, snoop_addr);
    end

    assign cpu_line     = data_q[cpu_lookup.way][cpu_addr.f.index];
    assign snoop_line   = data_q[snoop_lookup.way][snoop_addr.f.index];
    assign victim_state = state_q[victim_way][cpu_addr.f.index];   // Same set as the CPU port
    assign victim_tag   = tag_q[victim_way][cpu_addr.f.index];
    assign victim_line  = data_q[victim_way][cpu_addr.f.index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                for (int s = 0; s < `L1_NUM_SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                    state_q[w][s] <= I;
                end
            end
        end else begin
            if (line_wr.en) begin
                valid_q[line_wr.way][line_wr.set] <= (line_wr.state != I);
                state_q[line_wr.way][line_wr.set] <= line_wr.state;
            end
            // Applied last, a snoop overrides a same-line install
            if (state_wr.en) begin
                valid_q[state_wr.way][state_wr.set] <= (state_wr.state != I);
                state_q[state_wr.way][state_wr.set] <= state_wr.state;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_wr.en) begin
            tag_q[line_wr.way][line_wr.set]  <= line_wr.tag;
            data_q[line_wr.way][line_wr.set] <= line_wr.data;
        end
    end

    // A tag is never installed twice in one set
    a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(cpu_match) && $onehot0(snoop_match));

endmodule

/* hdl/lru_tracker.sv */
// Per-set age counters for LRU replacement
// Victim is the oldest way of the addressed set; a touch makes a way youngest
`timescale 1ns/1ps
`include "cache_macros.svh"

module lru_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`L1_INDEX_W-1:0] set,
    input  logic                   touch,
    input  logic [`L1_WAY_W-1:0]   touch_way,
    output logic [`L1_WAY_W-1:0]   victim_way
);
    logic [`L1_WAY_W-1:0]    age_q [`L1_NUM_SETS][`L1_NUM_WAYS];
    logic [`L1_NUM_WAYS-1:0] ages_seen;

    always_comb begin
        victim_way = '0;
        ages_seen  = '0;
        for (int w = 1; w < `L1_NUM_WAYS; w++) begin
            if (age_q[set][w] > age_q[set][victim_way]) victim_way = w[`L1_WAY_W-1:0];
        end
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            ages_seen[age_q[set][w]] = 1'b1;
        end
    end

    // Only ways younger than the touched one age, so 3 is never passed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `L1_NUM_SETS; s++) begin
                for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                    age_q[s][w] <= w[`L1_WAY_W-1:0];
                end
            end
        end else if (touch) begin
            for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                if (w == touch_way) begin
                    age_q[set][w] <= '0;
                end else if (age_q[set][w] < age_q[set][touch_way]) begin
                    age_q[set][w] <= age_q[set][w] + 1'b1;
                end
            end
        end
    end

    a_age_perm: assert property (@(posedge clk) disable iff (!rst_n) &ages_seen);

endmodule

/* hdl/snoop_unit.sv */
// Answers the other cache's bus traffic one cycle after snoop_valid
// Supplies the line on reads and downgrades or invalidates the local copy
`timescale 1ns/1ps

module snoop_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::snoop_req_s  snoop_req,
    input  cache_pkg::lookup_s     snoop_lookup,
    input  cache_pkg::line_t       snoop_line,
    output cache_pkg::snoop_rsp_s  snoop_rsp,
    output cache_pkg::state_wr_s   state_wr
);
    import cache_pkg::*;

    cache_addr_u addr;
    logic        hit;
    logic        supply;
    logic        rsp_hit_q;
    line_t       rsp_data_q;

    assign addr   = snoop_req.addr;
    assign hit    = snoop_req.valid && snoop_lookup.hit;
    assign supply = hit && (snoop_req.cmd == RD || snoop_req.cmd == RDX);

    always_comb begin
        state_wr.way   = snoop_lookup.way;
        state_wr.set   = addr.f.index;
        state_wr.en    = 1'b0;
        state_wr.state = I;
        if (hit && snoop_req.cmd == RD) begin
            state_wr.en    = (snoop_lookup.state == M);   // S stays S
            state_wr.state = S;
        end else if (hit && (snoop_req.cmd == RDX || snoop_req.cmd == UPGR)) begin
            state_wr.en    = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_hit_q <= 1'b0;
        end else begin
            rsp_hit_q <= hit;
        end
    end

    always_ff @(posedge clk) begin
        rsp_data_q <= supply ? snoop_line : '0;
    end

    assign snoop_rsp = '{hit: rsp_hit_q, data: rsp_data_q};

endmodule

/* hdl/l1_cache_top.sv */
// Private L1 data cache with MSI snooping, one of two on a shared bus
// CPU port, bus request port, L2 writeback port and snoop port
`timescale 1ns/1ps
`include "cache_macros.svh"

module l1_cache_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::cpu_req_s    cpu_req,
    output logic [31:0]            cpu_rdata,
    output logic                   cpu_ready,
    output cache_pkg::bus_req_s    bus_out,
    input  logic                   bus_grant,
    input  logic                   bus_valid,
    input  cache_pkg::line_t       bus_data_in,
    output cache_pkg::l2_wb_s      l2_wb,
    input  logic                   l2_ready,
    input  cache_pkg::snoop_req_s  snoop_req,
    output cache_pkg::snoop_rsp_s  snoop_rsp
);
    import cache_pkg::*;

    cache_addr_u          lookup_addr;
    lookup_s              cpu_lookup;
    lookup_s              snoop_lookup;
    line_t                hit_line;
    line_t                victim_line;
    line_t                snoop_line;
    logic [`L1_WAY_W-1:0] victim_way;
    msi_e                 victim_state;
    logic [`L1_TAG_W-1:0] victim_tag;
    line_wr_s             line_wr;
    state_wr_s            state_wr;
    logic                 lru_touch;
    logic [`L1_WAY_W-1:0] lru_touch_way;

    cache_ctrl i_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_req       (cpu_req),
        .cpu_rdata     (cpu_rdata),
        .cpu_ready     (cpu_ready),
        .bus_out       (bus_out),
        .bus_grant     (bus_grant),
        .bus_valid     (bus_valid),
        .bus_data_in   (bus_data_in),
        .l2_wb         (l2_wb),
        .l2_ready      (l2_ready),
        .lookup_addr   (lookup_addr),
        .lookup        (cpu_lookup),
        .hit_line      (hit_line),
        .victim_way    (victim_way),
        .victim_state  (victim_state),
        .victim_tag    (victim_tag),
        .victim_line   (victim_line),
        .line_wr       (line_wr),
        .lru_touch     (lru_touch),
        .lru_touch_way (lru_touch_way)
    );

    cache_store i_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_addr     (lookup_addr),
        .cpu_lookup   (cpu_lookup),
        .cpu_line     (hit_line),
        .victim_way   (victim_way),
        .victim_state (victim_state),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .snoop_addr   (snoop_req.addr),   // Raw bus word, split inside
        .snoop_lookup (snoop_lookup),
        .snoop_line   (snoop_line),
        .line_wr      (line_wr),
        .state_wr     (state_wr)
    );

    lru_tracker i_lru (
        .clk        (clk),
        .rst_n      (rst_n),
        .set        (lookup_addr.f.index),
        .touch      (lru_touch),
        .touch_way  (lru_touch_way),
        .victim_way (victim_way)
    );

    snoop_unit i_snoop (
        .clk          (clk),
        .rst_n        (rst_n),
        .snoop_req    (snoop_req),
        .snoop_lookup (snoop_lookup),
        .snoop_line   (snoop_line),
        .snoop_rsp    (snoop_rsp),
        .state_wr     (state_wr)
    );

endmodule

/* test/bus_l2_model.sv */
// Bus and L2 responder for the cache testbench
// Acknowledges bus_req and l2_wr after resp_delay cycles and keeps the memory image
`timescale 1ns/1ps

module bus_l2_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [1:0]            resp_delay,
    input  cache_pkg::bus_req_s   bus_out,
    output logic                  bus_grant,
    output logic                  bus_valid,
    output cache_pkg::line_t      bus_data_in,
    input  cache_pkg::l2_wb_s     l2_wb,
    output logic                  l2_ready
);
    import cache_pkg::*;

    line_t mem [logic [27:0]];   // Keyed by line address
    int    wait_cnt;

    // Untouched lines hold their own word addresses, scrambled
    function automatic line_t read_line(input logic [27:0] la);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = {la, w[1:0], 2'b00} ^ 32'h5a5a_a5a5;
        end
        if (mem.exists(la)) l = mem[la];
        return l;
    endfunction

    initial begin
        bus_grant   = 1'b0;
        bus_valid   = 1'b0;
        bus_data_in = '0;
        l2_ready    = 1'b0;
        wait_cnt    = 0;
    end

    always @(posedge clk) begin
        #1;
        if (!rst_n || bus_grant || l2_ready) begin   // Ack lasts one cycle
            bus_grant = 1'b0;
            bus_valid = 1'b0;
            l2_ready  = 1'b0;
            wait_cnt  = 0;
        end else if (bus_out.req) begin
            if (wait_cnt == resp_delay) begin
                bus_data_in = read_line(bus_out.addr[31:4]);
                bus_grant   = 1'b1;
                bus_valid   = 1'b1;
            end else begin
                wait_cnt++;
            end
        end else if (l2_wb.wr) begin
            if (wait_cnt == resp_delay) begin
                mem[l2_wb.addr[31:4]] = l2_wb.wdata;
                l2_ready = 1'b1;
            end else begin
                wait_cnt++;
            end
        end
    end

endmodule

/* test/tb_l1_cache.sv */
// Testbench of the L1 cache: directed MSI scenarios with LFSR write data
// Checks are immediate assertions; bus and L2 come from bus_l2_model
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_l1_cache;
    import cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 60 * 40 + 600;   // ~60 requests of up to 40 cycles
    localparam logic [31:0] ADDR_A = 32'h0000_1234;
    localparam logic [31:0] ADDR_B = 32'h0000_2538;
    localparam logic [31:0] ADDR_C = 32'h0000_4044;
    localparam logic [31:0] ADDR_E = 32'h0009_9990;   // Never cached

    logic        clk = 1'b0;
    logic        rst_n;
    cpu_req_s    cpu_req;
    logic [31:0] cpu_rdata;
    logic        cpu_ready;
    bus_req_s    bus_out;
    logic        bus_grant;
    logic        bus_valid;
    line_t       bus_data_in;
    l2_wb_s      l2_wb;
    logic        l2_ready;
    snoop_req_s  snoop_req;
    snoop_rsp_s  snoop_rsp;
    logic [1:0]  resp_delay;

    logic [31:0] lfsr_q = 32'hfec1;
    int          errors = 0;
    int          cycles = 0;
    line_t       ref_mem [logic [27:0]];   // Lines the CPU wrote
    logic [31:0] set_order [$];             // Access order of the eviction set
    logic        bus_seen;
    logic        wb_seen;
    logic        wb_first;
    bus_cmd_e    seen_cmd;
    logic [31:0] seen_addr;
    logic [31:0] wb_addr;
    line_t       wb_data;
    logic [31:0] rdata;
    int          lat;
    logic [31:0] victim;

    l1_cache_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .cpu_rdata   (cpu_rdata),
        .cpu_ready   (cpu_ready),
        .bus_out     (bus_out),
        .bus_grant   (bus_grant),
        .bus_valid   (bus_valid),
        .bus_data_in (bus_data_in),
        .l2_wb       (l2_wb),
        .l2_ready    (l2_ready),
        .snoop_req   (snoop_req),
        .snoop_rsp   (snoop_rsp)
    );

    bus_l2_model i_model (
        .clk         (clk),
        .rst_n       (rst_n),
        .resp_delay  (resp_delay),
        .bus_out     (bus_out),
        .bus_grant   (bus_grant),
        .bus_valid   (bus_valid),
        .bus_data_in (bus_data_in),
        .l2_wb       (l2_wb),
        .l2_ready    (l2_ready)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic line_t exp_line(input logic [31:0] addr);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = {addr[31:4], w[1:0], 2'b00} ^ 32'h5a5a_a5a5;
        end
        if (ref_mem.exists(addr[31:4])) l = ref_mem[addr[31:4]];
        return l;
    endfunction

    function automatic logic [31:0] exp_word(input logic [31:0] addr);
        line_t l;
        l = exp_line(addr);
        return l[addr[3:2]*32 +: 32];
    endfunction

    task automatic expect_eq(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    // First bus request and first writeback of the running access, mid-cycle
    always @(negedge clk) begin
        if (l2_wb.wr && !wb_seen) begin
            wb_seen  = 1'b1;
            wb_first = !bus_seen;
            wb_addr  = l2_wb.addr;
            wb_data  = l2_wb.wdata;
        end
        if (bus_out.req && !bus_seen) begin
            bus_seen  = 1'b1;
            seen_cmd  = bus_out.cmd;
            seen_addr = bus_out.addr;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, errors: %0d", cycles, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Starts and ends 1 ns after a rising edge
    task automatic access(input logic [31:0] addr, input logic wr,
                          input logic [31:0] wdata, input logic [3:0] be);
        line_t l;
        bus_seen   = 1'b0;
        wb_seen    = 1'b0;
        wb_first   = 1'b0;
        resp_delay = 2'(rand_bits(2));
        cpu_req    = '{addr: addr, wdata: wdata, byte_en: be, rd: !wr, wr: wr};
        @(posedge clk);
        #1;
        cpu_req.rd = 1'b0;
        cpu_req.wr = 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!cpu_ready);
        rdata = cpu_rdata;
        if (wr) begin
            l = exp_line(addr);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) l[addr[3:2]*32 + b*8 +: 8] = wdata[b*8 +: 8];
            end
            ref_mem[addr[31:4]] = l;
        end
    endtask

    task automatic read_word(input logic [31:0] addr);
        access(addr, 1'b0, '0, '0);
        expect_eq("cpu_rdata", rdata, exp_word(addr));
    endtask

    task automatic write_word(input logic [31:0] addr);
        logic [31:0] d;
        logic [3:0]  be;
        d  = rand_bits(32);
        be = 4'(rand_bits(4));
        access(addr, 1'b1, d, be);
    endtask

    task automatic expect_bus(input bus_cmd_e cmd, input logic [31:0] addr);
        expect_true(bus_seen, "access finished without a bus request");
        expect_eq("bus_out.cmd", seen_cmd, cmd);
        expect_eq("bus_out.addr", seen_addr, addr);
    endtask

    task automatic snoop(input bus_cmd_e cmd, input logic [31:0] addr,
                         input logic exp_hit, input logic check_data);
        snoop_req = '{valid: 1'b1, cmd: cmd, addr: addr};
        @(posedge clk);
        #1;
        snoop_req.valid = 1'b0;
        expect_eq("snoop_rsp.hit", snoop_rsp.hit, exp_hit);
        if (check_data) expect_eq("snoop_rsp.data", snoop_rsp.data, exp_line(addr));
    endtask

    initial begin
        rst_n      = 1'b0;
        cpu_req    = '0;
        snoop_req  = '{valid: 1'b0, cmd: IDLE, addr: '0};
        resp_delay = 2'd0;
        bus_seen   = 1'b0;
        wb_seen    = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        read_word(ADDR_A);                       // Miss, then hit
        expect_bus(RD, ADDR_A);
        read_word(ADDR_A);
        expect_eq("hit latency", lat, 3);
        expect_true(!bus_seen, "read hit raised bus_req");

        write_word(ADDR_B);                      // Write miss
        expect_bus(RDX, ADDR_B);
        read_word(ADDR_B);
        expect_true(!bus_seen, "read after write miss raised bus_req");

        write_word(ADDR_A);                      // S line upgrade
        expect_bus(UPGR, ADDR_A);
        read_word(ADDR_A);

        snoop(RD, ADDR_B, 1'b1, 1'b1);           // M to S, line supplied
        write_word(ADDR_B);
        expect_bus(UPGR, ADDR_B);
        read_word(ADDR_B);

        read_word(ADDR_C);                       // Invalidations of a clean line
        snoop(RDX, ADDR_C, 1'b1, 1'b0);
        read_word(ADDR_C);
        expect_bus(RD, ADDR_C);
        snoop(UPGR, ADDR_C, 1'b1, 1'b0);
        read_word(ADDR_C);
        expect_bus(RD, ADDR_C);
        snoop(RD, ADDR_E, 1'b0, 1'b0);

        for (int k = 0; k < 5; k++) begin        // Five tags into set 5
            logic [31:0] a;
            a = {24'h000100 + k[23:0], 4'h5, 4'h8};
            if (k == 4) victim = set_order.pop_front();
            write_word(a);
            expect_bus(RDX, a);
            if (k == 4) begin
                expect_true(wb_seen && wb_first, "eviction did not write back before bus_req");
                expect_eq("l2_wb.addr", wb_addr, {victim[31:4], 4'h0});
                expect_eq("l2_wb.wdata", wb_data, exp_line(victim));
            end
            set_order.push_back(a);
        end
        read_word(victim);                       // Comes back from L2
        expect_bus(RD, victim);

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_store.sv
hdl/lru_tracker.sv
hdl/snoop_unit.sv
hdl/l1_cache_top.sv
test/bus_l2_model.sv
test/tb_l1_cache.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l1_cache -f src.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
grep -q "TEST PASS" sim.log
